// ==== hdl/quant_defs.svh ====
`ifndef QUANT_DEFS_SVH
`define QUANT_DEFS_SVH

// Coefficient width, the same at the input and the output
`define QUANT_COEF_W 11

// Reciprocal width, which holds 4096/Q for Q down to 1
`define QUANT_RECIP_W 13

// Signed product width of one coefficient times one reciprocal
`define QUANT_PROD_W 24

// Fraction bits in the product, with the round bit just below this position
`define QUANT_FRAC_SHIFT 12

// Block geometry
`define QUANT_ROW_LEN 8
`define QUANT_ROWS 8

// Every table entry resets to Q = 1
`define QUANT_RECIP_RESET 4096

// Table entry n sits at byte address 4*n, so address bits 7:2 select the entry
`define QUANT_APB_ADDR_W 12
`define QUANT_APB_DATA_W 32

`endif

// ==== hdl/quant_pkg.sv ====
`default_nettype none

`include "quant_defs.svh"

package quant_pkg;

	typedef logic signed [`QUANT_COEF_W-1:0] coef_t;
	typedef logic [`QUANT_RECIP_W-1:0] recip_t;
	typedef logic [$clog2(`QUANT_ROWS)-1:0] row_idx_t;

	// One row of an 8x8 block, tagged with its row index
	typedef struct packed {
		row_idx_t row;
		coef_t [`QUANT_ROW_LEN-1:0] coef;
	} coef_row_t;

	// Reciprocals for one table row, element i matching coefficient i
	typedef recip_t [`QUANT_ROW_LEN-1:0] recip_row_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`QUANT_APB_ADDR_W-1:0] paddr;
		logic [`QUANT_APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [`QUANT_APB_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/quant_table_regs.sv ====
`default_nettype none

`include "quant_defs.svh"

module quant_table_regs (
	input  logic                  clk,
	input  logic                  rst,
	input  quant_pkg::apb_req_t   apb_req,
	output quant_pkg::apb_rsp_t   apb_rsp,
	input  quant_pkg::row_idx_t   tbl_row,
	output quant_pkg::recip_row_t recip_row
);

	import quant_pkg::*;

	localparam int IDX_W = $clog2(`QUANT_ROWS * `QUANT_ROW_LEN);
	localparam int COL_W = $clog2(`QUANT_ROW_LEN);

	// Reciprocal table, stored as one packed word per block row
	recip_row_t tbl [`QUANT_ROWS];

	logic             access;
	logic             in_range;
	logic [IDX_W-1:0] idx;
	row_idx_t         idx_row;
	logic [COL_W-1:0] idx_col;
	recip_t           rd_entry;

	assign access = apb_req.psel && apb_req.penable;

	// Entry index sits above the byte offset, and any higher address bit is out of range
	assign idx      = apb_req.paddr[IDX_W+1:2];
	assign in_range = (apb_req.paddr[`QUANT_APB_ADDR_W-1:IDX_W+2] == '0);
	assign idx_row  = idx[IDX_W-1:COL_W];
	assign idx_col  = idx[COL_W-1:0];
	assign rd_entry = tbl[idx_row][idx_col];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `QUANT_ROWS; r++) begin
				for (int c = 0; c < `QUANT_ROW_LEN; c++) begin
					tbl[r][c] <= recip_t'(`QUANT_RECIP_RESET);
				end
			end
		end else if (access && apb_req.pwrite && in_range) begin
			tbl[idx_row][idx_col] <= apb_req.pwdata[`QUANT_RECIP_W-1:0];
		end
	end

	// No wait states, so the response is complete in the access phase
	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = access && !in_range;
		apb_rsp.prdata  = '0;
		if (access && !apb_req.pwrite && in_range) begin
			apb_rsp.prdata = {{(`QUANT_APB_DATA_W - `QUANT_RECIP_W){1'b0}}, rd_entry};
		end
	end

	// The multiply stage reads this row directly from the table
	assign recip_row = tbl[tbl_row];

endmodule

`default_nettype wire

// ==== hdl/quant_lane.sv ====
`default_nettype none

`include "quant_defs.svh"

module quant_lane (
	input  logic              clk,
	input  logic              rst,
	input  logic              mul_en,
	input  logic              dly_en,
	input  logic              rnd_en,
	input  quant_pkg::coef_t  coef,
	input  quant_pkg::recip_t recip,
	output quant_pkg::coef_t  q
);

	import quant_pkg::*;

	localparam int PROD_W = `QUANT_PROD_W;
	localparam int FRAC   = `QUANT_FRAC_SHIFT;
	localparam int COEF_W = `QUANT_COEF_W;

	logic signed [PROD_W-1:0] coef_ext;
	logic signed [PROD_W-1:0] recip_ext;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] prod_dly;
	logic [COEF_W-1:0]        rnd_sum;

	// Reciprocal is unsigned, so it gets a zero top bit before the signed multiply
	assign coef_ext  = {{(PROD_W - COEF_W){coef[COEF_W-1]}}, coef};
	assign recip_ext = {{(PROD_W - `QUANT_RECIP_W){1'b0}}, recip};

	always_ff @(posedge clk) begin
		if (mul_en) begin
			prod <= coef_ext * recip_ext;
		end
	end

	// Balance register keeping the lane in step with the valid chain
	always_ff @(posedge clk) begin
		if (dly_en) begin
			prod_dly <= prod;
		end
	end

	// Shift out the fraction and add the round bit, wrapping modulo 2^11
	assign rnd_sum = prod_dly[FRAC+COEF_W-1:FRAC]
		+ {{(COEF_W - 1){1'b0}}, prod_dly[FRAC-1]};

	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (rnd_en) begin
			q <= coef_t'(rnd_sum);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/quant_row_pipe.sv ====
`default_nettype none

`include "quant_defs.svh"

module quant_row_pipe (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  quant_pkg::coef_row_t  in_row,
	output quant_pkg::row_idx_t   tbl_row,
	input  quant_pkg::recip_row_t recip_row,
	output logic                  out_valid,
	output quant_pkg::coef_row_t  out_row
);

	import quant_pkg::*;

	localparam int MUL = 0;
	localparam int DLY = 1;
	localparam int RND = 2;

	coef_t [`QUANT_ROW_LEN-1:0] cap_coef;
	row_idx_t                   cap_idx;
	logic                       cap_valid;

	// One valid bit and one row index per stage after capture
	logic [RND:MUL]     vld_q;
	row_idx_t [RND:MUL] row_q;

	coef_t [`QUANT_ROW_LEN-1:0] lane_q;

	// Capture stage holds the accepted row until the next accepted beat
	always_ff @(posedge clk) begin
		if (in_valid) begin
			cap_coef <= in_row.coef;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cap_valid <= 1'b0;
			cap_idx   <= '0;
			vld_q     <= '0;
			row_q     <= '0;
		end else begin
			cap_valid <= in_valid;
			vld_q     <= {vld_q[DLY:MUL], cap_valid};
			if (in_valid) begin
				cap_idx <= in_row.row;
			end
			// The row index moves on the same enables as the lane data
			if (cap_valid) begin
				row_q[MUL] <= cap_idx;
			end
			if (vld_q[MUL]) begin
				row_q[DLY] <= row_q[MUL];
			end
			if (vld_q[DLY]) begin
				row_q[RND] <= row_q[DLY];
			end
		end
	end

	assign tbl_row = cap_idx;

	for (genvar i = 0; i < `QUANT_ROW_LEN; i++) begin : g_lane
		quant_lane u_lane (
			.clk    (clk),
			.rst    (rst),
			.mul_en (cap_valid),
			.dly_en (vld_q[MUL]),
			.rnd_en (vld_q[DLY]),
			.coef   (cap_coef[i]),
			.recip  (recip_row[i]),
			.q      (lane_q[i])
		);
	end

	assign out_valid = vld_q[RND];

	always_comb begin
		out_row.row  = row_q[RND];
		out_row.coef = lane_q;
	end

endmodule

`default_nettype wire

// ==== hdl/chroma_quantizer.sv ====
`default_nettype none

module chroma_quantizer (
	input  logic                 clk,
	input  logic                 rst,
	input  quant_pkg::apb_req_t  apb_req,
	output quant_pkg::apb_rsp_t  apb_rsp,
	input  logic                 in_valid,
	input  quant_pkg::coef_row_t in_row,
	output logic                 out_valid,
	output quant_pkg::coef_row_t out_row
);

	import quant_pkg::*;

	// Row lookup between the pipeline and the table
	row_idx_t   tbl_row;
	recip_row_t recip_row;

	// The multiply stage reads the table with no register in between
	// Writes must therefore wait until no row is in flight
	quant_table_regs u_table (
		.clk       (clk),
		.rst       (rst),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.tbl_row   (tbl_row),
		.recip_row (recip_row)
	);

	quant_row_pipe u_pipe (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_row    (in_row),
		.tbl_row   (tbl_row),
		.recip_row (recip_row),
		.out_valid (out_valid),
		.out_row   (out_row)
	);

endmodule

`default_nettype wire

// ==== sim/tb_chroma_quantizer.sv ====
`default_nettype none

`include "quant_defs.svh"

module tb_chroma_quantizer;

	timeunit 1ns;
	timeprecision 100ps;

	import quant_pkg::*;

	localparam string STIM_FILE = "sim/quant_stim.txt";
	localparam int DRIVE_DLY = 2;
	localparam int DRAIN_LIMIT = 12;
	// out_valid rises on the third edge after the edge that accepts the row
	localparam logic [31:0] LATENCY = 32'd3;

	typedef struct packed {
		coef_row_t   row;
		logic [31:0] accept_cycle;
	} exp_beat_t;

	logic      clk;
	logic      rst;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	logic      in_valid;
	coef_row_t in_row;
	logic      out_valid;
	coef_row_t out_row;

	logic [31:0] cycle_cnt = '0;
	exp_beat_t   exp_q [$];

	int error_count = 0;
	int check_count = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int watchdog_cycles = 0;

	chroma_quantizer DUT (
		.clk       (clk),
		.rst       (rst),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.in_valid  (in_valid),
		.in_row    (in_row),
		.out_valid (out_valid),
		.out_row   (out_row)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 32'd1;
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			test_errors++;
			$display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected,
				$time);
		end
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		test_errors++;
		$display("ERROR: %s at %0t", msg, $time);
	endtask

	task automatic next_drive_slot();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
		logic exp_err;
		// Any address bit above bit 7 lies outside the table
		exp_err = |addr[`QUANT_APB_ADDR_W-1:8];
		next_drive_slot();
		in_valid        = 1'b0;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr[`QUANT_APB_ADDR_W-1:0];
		apb_req.pwdata  = data;
		next_drive_slot();
		apb_req.penable = 1'b1;
		@(negedge clk);
		check($sformatf("pready on write 0x%03h", addr[`QUANT_APB_ADDR_W-1:0]),
			{31'b0, apb_rsp.pready}, 32'd1);
		check($sformatf("pslverr on write 0x%03h", addr[`QUANT_APB_ADDR_W-1:0]),
			{31'b0, apb_rsp.pslverr}, {31'b0, exp_err});
		next_drive_slot();
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		next_drive_slot();
		in_valid        = 1'b0;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr[`QUANT_APB_ADDR_W-1:0];
		apb_req.pwdata  = '0;
		next_drive_slot();
		apb_req.penable = 1'b1;
		// Read data is combinational during the access phase
		@(negedge clk);
		check($sformatf("pready on read 0x%03h", addr[`QUANT_APB_ADDR_W-1:0]),
			{31'b0, apb_rsp.pready}, 32'd1);
		check($sformatf("prdata[0x%03h]", addr[`QUANT_APB_ADDR_W-1:0]),
			apb_rsp.prdata, exp_data);
		check($sformatf("pslverr on read 0x%03h", addr[`QUANT_APB_ADDR_W-1:0]),
			{31'b0, apb_rsp.pslverr}, {31'b0, exp_err});
		next_drive_slot();
		apb_req = '0;
	endtask

	task automatic send_row(input coef_row_t in_r, input coef_row_t exp_r);
		exp_beat_t beat;
		next_drive_slot();
		apb_req  = '0;
		in_valid = 1'b1;
		in_row   = in_r;
		beat.row = exp_r;
		beat.accept_cycle = cycle_cnt + 32'd1;
		exp_q.push_back(beat);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			next_drive_slot();
			in_valid = 1'b0;
		end
	endtask

	task automatic end_test(input string name);
		int wait_cnt;
		next_drive_slot();
		in_valid = 1'b0;
		wait_cnt = 0;
		while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (exp_q.size() != 0) begin
			report_failure($sformatf("%0d expected rows never came out in test %s",
				exp_q.size(), name));
			exp_q.delete();
		end
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
			test_errors);
		test_errors = 0;
	endtask

	function automatic bit is_blank(input byte c);
		return (c == " " || c == "\t" || c == "\n" || c == "\r");
	endfunction

	function automatic string get_name(input string s);
		int first;
		int last;
		first = 0;
		while (first < s.len() && is_blank(s.getc(first))) begin
			first++;
		end
		last = first;
		while (last < s.len() && !is_blank(s.getc(last))) begin
			last++;
		end
		if (last == first) begin
			return "unnamed";
		end
		return s.substr(first, last - 1);
	endfunction

	// Compares every out_valid beat with the oldest row still expected
	always @(negedge clk) begin : output_monitor
		exp_beat_t beat;
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				report_failure($sformatf("out_valid high at cycle %0d with no row expected",
					cycle_cnt));
			end else begin
				beat = exp_q.pop_front();
				check("out_row.row", {29'b0, out_row.row}, {29'b0, beat.row.row});
				for (int i = 0; i < `QUANT_ROW_LEN; i++) begin
					check($sformatf("out_row.coef[%0d]", i), {21'b0, out_row.coef[i]},
						{21'b0, beat.row.coef[i]});
				end
				check("latency", cycle_cnt - beat.accept_cycle, LATENCY);
			end
		end
	end

	task automatic run_stimulus();
		int fd;
		int rc;
		int n;
		string line;
		string rest;
		logic [7:0] cmd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] err;
		int v [17];
		coef_row_t in_r;
		coef_row_t exp_r;
		fd = $fopen(STIM_FILE, "r");
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.len() > 1) begin
				cmd  = line.getc(0);
				rest = line.substr(1, line.len() - 1);
				case (cmd)
					"W": begin
						n = $sscanf(rest, "%h %h", addr, data);
						if (n == 2) apb_write(addr, data);
						else report_failure($sformatf("malformed stimulus line: %s", line));
					end
					"R": begin
						n = $sscanf(rest, "%h %h %h", addr, data, err);
						if (n == 3) apb_read(addr, data, err[0]);
						else report_failure($sformatf("malformed stimulus line: %s", line));
					end
					"B": begin
						n = $sscanf(rest, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
							v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
							v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
						if (n == 17) begin
							in_r.row  = row_idx_t'(v[0]);
							exp_r.row = row_idx_t'(v[0]);
							// Casting to coef_t keeps the low 11 bits, the same as modulo 2^11
							for (int i = 0; i < `QUANT_ROW_LEN; i++) begin
								in_r.coef[i]  = coef_t'(v[1 + i]);
								exp_r.coef[i] = coef_t'(v[1 + `QUANT_ROW_LEN + i]);
							end
							send_row(in_r, exp_r);
						end else begin
							report_failure($sformatf("malformed stimulus line: %s", line));
						end
					end
					"G": begin
						n = $sscanf(rest, "%d", v[0]);
						if (n == 1) idle_cycles(v[0]);
						else report_failure($sformatf("malformed stimulus line: %s", line));
					end
					"T": end_test(get_name(rest));
					"#": ;
					default: report_failure($sformatf("unknown stimulus command: %s", line));
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("ERROR: watchdog expired after %0d cycles before the stimulus finished",
			watchdog_cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : main
		int fd;
		int rc;
		int line_count;
		string line;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_row   = '0;
		apb_req  = '0;
		line_count = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			report_failure($sformatf("could not open stimulus file %s", STIM_FILE));
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				if (rc > 0) line_count++;
			end
			$fclose(fd);
		end
		watchdog_cycles = (line_count + 50) * 20;

		repeat (8) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		@(negedge clk);
		check("out_valid after reset", {31'b0, out_valid}, 32'd0);
		check("out_row.row after reset", {29'b0, out_row.row}, 32'd0);
		for (int i = 0; i < `QUANT_ROW_LEN; i++) begin
			check($sformatf("out_row.coef[%0d] after reset", i), {21'b0, out_row.coef[i]},
				32'd0);
		end
		check("prdata after reset", apb_rsp.prdata, 32'd0);
		check("pslverr after reset", {31'b0, apb_rsp.pslverr}, 32'd0);

		if (line_count > 0) begin
			run_stimulus();
		end
		if (tests_run == 0) begin
			report_failure("no test ran to its end");
		end

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
			tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== chroma_quantizer.f ====
+incdir+hdl
hdl/quant_pkg.sv
hdl/quant_table_regs.sv
hdl/quant_lane.sv
hdl/quant_row_pipe.sv
hdl/chroma_quantizer.sv
sim/tb_chroma_quantizer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_chroma_quantizer \
	--Mdir obj_dir -o sim_chroma_quantizer \
	-f chroma_quantizer.f \
	&& ./obj_dir/sim_chroma_quantizer 2>&1 | tee "$LOG" \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -q "=== FAIL ===" "$LOG" \
	&& { echo "Simulation reported a failure, see $LOG"; exit 1; }

echo "Simulation finished without failures"
exit 0

// ==== sim/quant_stim.txt ====
# W addr data | R addr exp_data exp_err | B row z0..z7 q0..q7 | G cycles | T name
# Addresses and APB data in hex, row index, coefficients and gap lengths in decimal

G 3
R 000 00001000 0
R 01c 00001000 0
R 084 00001000 0
R 0fc 00001000 0
G 4
T reset_state

B 0 0 1 -1 1023 -1024 5 -5 100 0 1 -1 1023 -1024 5 -5 100
B 7 -512 511 2 -2 64 -64 300 -300 -512 511 2 -2 64 -64 300 -300
B 4 10 20 30 40 -10 -20 -30 -40 10 20 30 40 -10 -20 -30 -40
G 6
T identity

W 000 000000f0
W 004 000000e3
W 008 000000aa
W 00c 00000057
W 010 00000029
W 014 00000029
W 018 00000029
W 01c 00000029
W 020 000000e3
W 024 000000c3
W 028 0000009d
W 02c 0000003e
W 030 00000029
W 034 00000029
W 038 00000029
W 03c abcd0029
W 040 0001ffff
B 0 128 -300 -1024 500 1023 -1023 0 -50 8 -17 -42 11 10 -10 0 -1
B 1 18 -200 1000 -1024 49 -49 150 -1 1 -10 38 -15 0 0 2 0
B 2 1023 -3 4 5 -6 7 -8 9 -2 -3 4 5 -6 7 -8 9
B 3 7 -7 300 -300 1023 -1024 1 -1 7 -7 300 -300 1023 -1024 1 -1
G 6
T programmed_table

B 3 7 -7 300 -300 1023 -1024 1 -1 7 -7 300 -300 1023 -1024 1 -1
B 0 -128 300 1023 -500 100 -100 1000 -1000 -7 17 42 -11 1 -1 10 -10
B 1 18 -200 1000 -1024 49 -49 150 -1 1 -10 38 -15 0 0 2 0
G 2
B 2 1023 -3 4 5 -6 7 -8 9 -2 -3 4 5 -6 7 -8 9
B 0 128 -300 -1024 500 1023 -1023 0 -50 8 -17 -42 11 10 -10 0 -1
G 1
B 1 18 -200 1000 -1024 49 -49 150 -1 1 -10 38 -15 0 0 2 0
B 3 7 -7 300 -300 1023 -1024 1 -1 7 -7 300 -300 1023 -1024 1 -1
B 0 -128 300 1023 -500 100 -100 1000 -1000 -7 17 42 -11 1 -1 10 -10
G 6
T streaming

G 2
R 100 00000000 1
R 800 00000000 1
R 3fc 00000000 1
R f1c 00000000 1
W 100 00000005
W 104 00000123
W 9fc 00001fff
R 000 000000f0 0
R 004 000000e3 0
R 0fc 00001000 0
G 2
T apb_errors

R 008 000000aa 0
R 00c 00000057 0
R 024 000000c3 0
R 03c 00000029 0
R 040 00001fff 0
R 044 00001000 0
R 080 00001000 0
W 0f8 ffffe123
R 0f8 00000123 0
R 0f4 00001000 0
T table_readback
